/* list.f */
+incdir+hw
hw/icmp_pkg.sv
hw/icmp_strm_ifc.sv
hw/icmp_meta_ifc.sv
hw/icmp_hdr_parser.sv
hw/icmp_pld_fifo.sv
hw/icmp_reply_tx.sv
hw/icmp_echo_responder.sv
testbench/icmp_echo_props.sv
testbench/icmp_echo_tb.sv

/* testbench/icmp_echo_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "icmp_params.svh"

module icmp_echo_tb;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  logic        clk;
  logic        fsm_rst;
  logic [7:0]  rx_dat;
  logic        rx_val;
  logic        rx_sof;
  logic        rx_eof;
  logic [31:0] rx_src_ip;
  logic [15:0] rx_ip_id;
  logic [7:0]  rx_ip_qos;
  logic [15:0] rx_ip_len;
  logic [31:0] dev_ip;
  logic        tx_rdy;
  logic        tx_req;
  logic        tx_err;
  logic [7:0]  tx_dat;
  logic        tx_val;
  logic        tx_sof;
  logic        tx_eof;
  logic [31:0] tx_src_ip;
  logic [31:0] tx_dst_ip;
  logic [15:0] tx_ip_id;
  logic [7:0]  tx_ip_qos;
  logic [15:0] tx_ip_len;
  logic [7:0]  tx_ttl;
  logic        busy;

  integer      seed = 53;
  int          errors = 0;
  int          checks = 0;
  int          mark = 0;   // Error count when the current test started
  logic [7:0]  req_q[$];   // Request message, header first
  logic [7:0]  exp_q[$];   // Expected reply message

  icmp_echo_responder i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    checks++;
    assert (act === exp) else begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s: %s", name, (errors == mark) ? "ok" : "failed");
    mark = errors;
  endtask

  task automatic build_request(input logic [7:0] icmp_type, input logic [15:0] cks,
                               input int n);
    logic [63:0] hdr;
    hdr = {icmp_type, 8'h00, cks, 16'($random(seed)), 16'($random(seed))};
    req_q.delete();
    for (int i = 0; i < `ICMP_HDR_LEN; i++)
      req_q.push_back(hdr[63 - 8 * i -: 8]);
    for (int i = 0; i < n; i++)
      req_q.push_back(8'($random(seed)));
  endtask

  task automatic send_request(input bit gaps);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (busy !== 1'b0 && t < TIMEOUT);
    if (busy !== 1'b0) begin
      $display("At %0t ns busy never fell, request not sent", $time);
      errors++;
      return;
    end
    for (int i = 0; i < req_q.size(); i++) begin
      @(posedge clk);
      rx_dat <= req_q[i];
      rx_val <= 1'b1;
      rx_sof <= (i == 0);
      rx_eof <= (i == req_q.size() - 1);
      if (i == 0) begin
        rx_src_ip <= $random(seed);
        rx_ip_id  <= 16'($random(seed));
        rx_ip_qos <= 8'($random(seed));
        rx_ip_len <= 16'(20 + req_q.size());  // IPv4 header plus ICMP message
      end
      if (gaps && ($random(seed) % 3 == 0) && (i < req_q.size() - 1)) begin
        @(posedge clk);
        rx_val <= 1'b0;
        rx_sof <= 1'b0;
        rx_eof <= 1'b0;
      end
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_sof <= 1'b0;
    rx_eof <= 1'b0;
  endtask

  // Answers tx_rdy and checks the reply
  // A non-negative err_at aborts the reply at that byte
  task automatic run_reply(input int err_at);
    int sum;
    int t;
    exp_q = req_q;
    exp_q[0] = 8'h00;  // Echo reply
    exp_q[1] = 8'h00;
    sum = {exp_q[2], exp_q[3]} + 32'h0800;
    if (sum > 32'hFFFF)
      sum = sum - 32'hFFFF;  // End-around carry
    exp_q[2] = sum[15:8];
    exp_q[3] = sum[7:0];
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (tx_rdy !== 1'b1 && t < TIMEOUT);
    if (tx_rdy !== 1'b1) begin
      $display("At %0t ns tx_rdy never rose for an echo request", $time);
      errors++;
      return;
    end
    check_value("busy", busy, 1'b1);
    @(posedge clk);
    tx_req <= 1'b1;
    @(posedge clk);
    tx_req <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < exp_q.size(); i++) begin
      if (i == err_at) begin
        @(posedge clk);
        tx_err <= 1'b1;
        @(posedge clk);
        tx_err <= 1'b0;
        @(negedge clk);
        break;
      end
      check_value("tx_val", tx_val, 1'b1);
      check_value("tx_sof", tx_sof, i == 0);
      check_value("tx_eof", tx_eof, i == exp_q.size() - 1);
      check_value($sformatf("tx_dat byte %0d", i), tx_dat, exp_q[i]);
      @(negedge clk);
    end
    check_value("tx_val", tx_val, 1'b0);
    check_value("busy", busy, 1'b0);
    if (err_at < 0) begin
      check_value("tx_dst_ip", tx_dst_ip, rx_src_ip);
      check_value("tx_src_ip", tx_src_ip, dev_ip);
      check_value("tx_ip_id", tx_ip_id, rx_ip_id);
      check_value("tx_ip_qos", tx_ip_qos, rx_ip_qos);
      check_value("tx_ip_len", tx_ip_len, rx_ip_len);
      check_value("tx_ttl", tx_ttl, 8'd128);
    end
  endtask

  task automatic echo_round(input logic [15:0] cks, input int n, input bit gaps,
                            input int err_at);
    build_request(8'd8, cks, n);
    send_request(gaps);
    run_reply(err_at);
  endtask

  task automatic expect_no_reply();
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      check_value("tx_rdy", tx_rdy, 1'b0);
      check_value("busy", busy, 1'b0);
    end
  endtask

  task automatic test_echo_payload();
    echo_round(16'($random(seed)), 40, 1'b0, -1);
    report_test("echo with 40-byte payload");
  endtask

  task automatic test_header_only();
    echo_round(16'hFA00, 0, 1'b0, -1);
    report_test("header-only echo with carry fold");
  endtask

  task automatic test_drops();
    build_request(8'd13, 16'($random(seed)), 12);  // Timestamp request
    send_request(1'b0);
    expect_no_reply();
    build_request(8'd8, 16'($random(seed)), `ICMP_PLD_DEPTH + 1);
    send_request(1'b0);
    expect_no_reply();
    echo_round(16'($random(seed)), 20, 1'b0, -1);
    report_test("drop of type 13 and oversized echo");
  endtask

  task automatic test_abort();
    echo_round(16'($random(seed)), 30, 1'b0, 15);
    echo_round(16'($random(seed)), 16, 1'b0, -1);
    report_test("reply aborted by tx_err");
  endtask

  task automatic test_back_to_back();
    echo_round(16'($random(seed)), 24, 1'b1, -1);
    echo_round(16'($random(seed)), 33, 1'b1, -1);
    report_test("two echoes with input gaps");
  endtask

  initial begin
    fsm_rst   <= 1'b1;
    rx_dat    <= 8'h00;
    rx_val    <= 1'b0;
    rx_sof    <= 1'b0;
    rx_eof    <= 1'b0;
    rx_src_ip <= 32'h0;
    rx_ip_id  <= 16'h0;
    rx_ip_qos <= 8'h0;
    rx_ip_len <= 16'h0;
    dev_ip    <= 32'hC0A8_0001;
    tx_req    <= 1'b0;
    tx_err    <= 1'b0;
    repeat (16) @(posedge clk);
    fsm_rst <= 1'b0;
    test_echo_payload();
    test_header_only();
    test_drops();
    test_abort();
    test_back_to_back();
    errors = errors + i_dut.i_props.fail_cnt;
    $display("Tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/icmp_echo_props.sv */
`default_nettype none
`timescale 1ns/1ps

// Reply side protocol of the responder
module icmp_echo_props (
  input logic clk,
  input logic fsm_rst,
  input logic tx_rdy,
  input logic tx_req,
  input logic tx_err,
  input logic tx_val,
  input logic tx_sof,
  input logic tx_eof,
  input logic busy
);

  int fail_cnt = 0;

  sof_with_val: assert property (@(posedge clk) disable iff (fsm_rst) tx_sof |-> tx_val)
    else begin
      $error("tx_sof high without tx_val");
      fail_cnt++;
    end

  rdy_falls: assert property (@(posedge clk) disable iff (fsm_rst)
      tx_rdy && tx_req |=> !tx_rdy)
    else begin
      $error("tx_rdy still high after tx_req");
      fail_cnt++;
    end

  val_until_eof: assert property (@(posedge clk) disable iff (fsm_rst)
      tx_val && !tx_eof && !tx_err |=> tx_val)
    else begin
      $error("tx_val dropped before tx_eof");
      fail_cnt++;
    end

  // Outputs idle one cycle into reset
  reset_idle: assert property (@(posedge clk)
      fsm_rst |=> !(tx_rdy || tx_val || tx_sof || tx_eof || busy))
    else begin
      $error("Reply outputs not low after reset");
      fail_cnt++;
    end

endmodule

bind icmp_echo_responder icmp_echo_props i_props (.*);

`default_nettype wire

/* hw/icmp_echo_responder.sv */
`default_nettype none
`timescale 1ns/1ps

module icmp_echo_responder (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic [7:0]         rx_dat,
  input  logic               rx_val,
  input  logic               rx_sof,
  input  logic               rx_eof,
  input  icmp_pkg::ip_addr_t rx_src_ip,
  input  logic [15:0]        rx_ip_id,
  input  logic [7:0]         rx_ip_qos,
  input  logic [15:0]        rx_ip_len,
  input  icmp_pkg::ip_addr_t dev_ip,
  output logic               tx_rdy,
  input  logic               tx_req,
  input  logic               tx_err,
  output logic [7:0]         tx_dat,
  output logic               tx_val,
  output logic               tx_sof,
  output logic               tx_eof,
  output icmp_pkg::ip_addr_t tx_src_ip,
  output icmp_pkg::ip_addr_t tx_dst_ip,
  output logic [15:0]        tx_ip_id,
  output logic [7:0]         tx_ip_qos,
  output logic [15:0]        tx_ip_len,
  output logic [7:0]         tx_ttl,
  output logic               busy
);

  icmp_strm_ifc rx_strm ();
  icmp_strm_ifc tx_strm ();
  icmp_meta_ifc meta ();

  logic [7:0] fifo_dat;
  logic       fifo_rd;
  logic       fifo_flush;

  assign rx_strm.dat = rx_dat;
  assign rx_strm.val = rx_val;
  assign rx_strm.sof = rx_sof;
  assign rx_strm.eof = rx_eof;

  assign tx_dat = tx_strm.dat;
  assign tx_val = tx_strm.val;
  assign tx_sof = tx_strm.sof;
  assign tx_eof = tx_strm.eof;
  assign busy   = meta.busy;

  icmp_hdr_parser u_parser (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .rx        (rx_strm.sink),
    .rx_src_ip (rx_src_ip),
    .rx_ip_id  (rx_ip_id),
    .rx_ip_qos (rx_ip_qos),
    .rx_ip_len (rx_ip_len),
    .dev_ip    (dev_ip),
    .meta      (meta.parser)
  );

  // Payload bytes of the request stream the parser sees
  icmp_pld_fifo u_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr_dat  (rx_strm.dat),
    .wr_en   (meta.hdr_done),
    .flush   (fifo_flush),
    .rd_en   (fifo_rd),
    .rd_dat  (fifo_dat),
    .empty   ()
  );

  icmp_reply_tx u_tx (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .meta       (meta.tx),
    .fifo_dat   (fifo_dat),
    .fifo_rd    (fifo_rd),
    .fifo_flush (fifo_flush),
    .tx_rdy     (tx_rdy),
    .tx_req     (tx_req),
    .tx_err     (tx_err),
    .tx         (tx_strm.source),
    .tx_src_ip  (tx_src_ip),
    .tx_dst_ip  (tx_dst_ip),
    .tx_ip_id   (tx_ip_id),
    .tx_ip_qos  (tx_ip_qos),
    .tx_ip_len  (tx_ip_len),
    .tx_ttl     (tx_ttl)
  );

endmodule

`default_nettype wire

/* hw/icmp_reply_tx.sv */
`default_nettype none
`timescale 1ns/1ps
`include "icmp_params.svh"

module icmp_reply_tx (
  input  logic               clk,
  input  logic               fsm_rst,
  icmp_meta_ifc.tx           meta,
  input  logic [7:0]         fifo_dat,
  output logic               fifo_rd,
  output logic               fifo_flush,
  output logic               tx_rdy,
  input  logic               tx_req,
  input  logic               tx_err,
  icmp_strm_ifc.source       tx,
  output icmp_pkg::ip_addr_t tx_src_ip,
  output icmp_pkg::ip_addr_t tx_dst_ip,
  output logic [15:0]        tx_ip_id,
  output logic [7:0]         tx_ip_qos,
  output logic [15:0]        tx_ip_len,
  output logic [7:0]         tx_ttl
);
  import icmp_pkg::*;

  logic [`ICMP_HDR_LEN-1:0][7:0] hdr_sr;
  ipv4_meta_t  ip_r;
  logic [15:0] pld_len;
  logic [15:0] byte_cnt;
  logic        load;
  logic        start;
  logic        abort;
  logic        near_end;
  logic        pld_phase;

  assign load      = meta.accept && !meta.busy;
  assign start     = tx_rdy && tx_req;
  assign abort     = meta.busy && tx_err;
  assign near_end  = tx.val && (byte_cnt == pld_len + 16'(`ICMP_HDR_LEN - 2));  // Byte before eof
  assign pld_phase = byte_cnt >= 16'(`ICMP_HDR_LEN);

  assign fifo_flush = meta.drop || abort || tx.eof;

  always_ff @(posedge clk) begin
    if (fsm_rst || abort) begin
      meta.busy <= 1'b0;
      tx_rdy    <= 1'b0;
    end else begin
      if (load) begin
        meta.busy <= 1'b1;
        tx_rdy    <= 1'b1;
      end else if (start) begin
        tx_rdy <= 1'b0;
      end
      if (tx.eof) meta.busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || abort) begin
      tx.val   <= 1'b0;
      tx.sof   <= 1'b0;
      tx.eof   <= 1'b0;
      byte_cnt <= '0;
    end else begin
      if (start) begin
        tx.val   <= 1'b1;
        tx.sof   <= 1'b1;
        byte_cnt <= '0;
      end else if (tx.val) begin
        tx.sof   <= 1'b0;
        byte_cnt <= byte_cnt + 16'd1;
      end
      tx.eof <= near_end;
      if (tx.eof) tx.val <= 1'b0;
    end
  end

  // Read starts two bytes before the header ends to cover the FIFO latency
  always_ff @(posedge clk) begin
    if (fsm_rst || abort) begin
      fifo_rd <= 1'b0;
    end else if (tx.val && (byte_cnt == 16'(`ICMP_HDR_LEN - 2)) && (pld_len != 16'd0)) begin
      fifo_rd <= 1'b1;
    end else if (near_end) begin
      fifo_rd <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hdr_sr  <= meta.hdr;
      ip_r    <= meta.ip;
      pld_len <= meta.pld_len;
    end else if (tx.val) begin
      hdr_sr <= {hdr_sr[`ICMP_HDR_LEN-2:0], 8'h00};
    end
  end

  assign tx.dat = pld_phase ? fifo_dat : hdr_sr[`ICMP_HDR_LEN-1];

  assign tx_src_ip = ip_r.src;
  assign tx_dst_ip = ip_r.dst;
  assign tx_ip_id  = ip_r.id;
  assign tx_ip_qos = ip_r.qos;
  assign tx_ip_len = ip_r.len;
  assign tx_ttl    = ip_r.ttl;

endmodule

`default_nettype wire

/* hw/icmp_pld_fifo.sv */
`default_nettype none
`timescale 1ns/1ps
`include "icmp_params.svh"

module icmp_pld_fifo (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic [7:0] wr_dat,
  input  logic       wr_en,
  input  logic       flush,
  input  logic       rd_en,
  output logic [7:0] rd_dat,
  output logic       empty
);

  localparam int AW = $clog2(`ICMP_PLD_DEPTH);

  logic [7:0]  mem [`ICMP_PLD_DEPTH];
  logic [AW:0] wr_ptr;  // Extra bit tells full from empty
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_wr;
  logic        do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Oversized payloads stop at full, the parser drops them anyway
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (fsm_rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr[AW-1:0]] <= wr_dat;
  end

  // Registered read, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (do_rd) rd_dat <= mem[rd_ptr[AW-1:0]];
  end

endmodule

`default_nettype wire

/* hw/icmp_hdr_parser.sv */
`default_nettype none
`timescale 1ns/1ps
`include "icmp_params.svh"

module icmp_hdr_parser (
  input  logic               clk,
  input  logic               fsm_rst,
  icmp_strm_ifc.sink         rx,
  input  icmp_pkg::ip_addr_t rx_src_ip,
  input  logic [15:0]        rx_ip_id,
  input  logic [7:0]         rx_ip_qos,
  input  logic [15:0]        rx_ip_len,
  input  icmp_pkg::ip_addr_t dev_ip,
  icmp_meta_ifc.parser       meta
);
  import icmp_pkg::*;

  logic [`ICMP_HDR_LEN-1:0][7:0] hdr_b;
  icmp_hdr_t   req_hdr;
  ipv4_meta_t  ip_r;
  logic [15:0] byte_cnt;
  logic [15:0] byte_idx;
  logic [15:0] msg_len;
  logic [16:0] cks_sum;
  logic        in_msg;
  logic        start;
  logic        take;
  logic        is_echo;
  logic        hdr_ok;
  logic        len_ok;

  // A request that shows up while a reply is pending is ignored whole
  assign start    = rx.val && rx.sof && !meta.busy;
  assign take     = start || (rx.val && in_msg && !rx.sof);
  assign byte_idx = rx.sof ? 16'd0 : byte_cnt;
  assign msg_len  = byte_idx + 16'd1;

  assign req_hdr = hdr_b;
  assign is_echo = (req_hdr.icmp_type == ICMP_ECHO_REQUEST) && (req_hdr.icmp_code == 8'h00);
  assign hdr_ok  = msg_len >= 16'(`ICMP_HDR_LEN);
  assign len_ok  = msg_len <= 16'(`ICMP_HDR_LEN + `ICMP_PLD_DEPTH);

  assign meta.hdr_done = take && (byte_idx >= 16'(`ICMP_HDR_LEN));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      in_msg      <= 1'b0;
      byte_cnt    <= '0;
      meta.accept <= 1'b0;
      meta.drop   <= 1'b0;
    end else begin
      meta.accept <= 1'b0;
      meta.drop   <= 1'b0;
      if (take) begin
        byte_cnt <= msg_len;
        in_msg   <= !rx.eof;
        if (rx.eof) begin
          if (is_echo && hdr_ok && len_ok) meta.accept <= 1'b1;
          else meta.drop <= 1'b1;  // Wrong type, short header or oversized payload
        end
      end
    end
  end

  // Header bytes land MSB first so the array lines up with icmp_hdr_t
  always_ff @(posedge clk) begin
    if (take && (byte_idx < 16'(`ICMP_HDR_LEN)))
      hdr_b[3'(`ICMP_HDR_LEN - 1) - byte_idx[2:0]] <= rx.dat;
    if (take && rx.eof)
      meta.pld_len <= msg_len - 16'(`ICMP_HDR_LEN);
  end

  // Reply addressing is fixed at sof
  always_ff @(posedge clk) begin
    if (start) begin
      ip_r.src <= dev_ip;
      ip_r.dst <= rx_src_ip;
      ip_r.id  <= rx_ip_id;
      ip_r.qos <= rx_ip_qos;
      ip_r.len <= rx_ip_len;
      ip_r.ttl <= 8'(`ICMP_REPLY_TTL);
    end
  end

  assign meta.ip = ip_r;

  // Type 8 to 0 raises the checksum by 0x0800, fold the carry back in
  assign cks_sum = {1'b0, req_hdr.cks} + 17'h00800;

  always_comb begin
    meta.hdr           = req_hdr;
    meta.hdr.icmp_type = ICMP_ECHO_REPLY;
    meta.hdr.icmp_code = 8'h00;
    meta.hdr.cks       = cks_sum[15:0] + 16'(cks_sum[16]);
  end

endmodule

`default_nettype wire

/* hw/icmp_meta_ifc.sv */
`default_nettype none
`timescale 1ns/1ps

interface icmp_meta_ifc;
  import icmp_pkg::*;

  icmp_hdr_t   hdr;       // Reply header, checksum already adjusted
  ipv4_meta_t  ip;        // Reply IPv4 fields
  logic [15:0] pld_len;
  logic        accept;    // Pulse, answer this message
  logic        drop;      // Pulse, discard this message
  logic        hdr_done;  // Current rx byte is a payload byte
  logic        busy;

  modport parser (
    output hdr,
    output ip,
    output pld_len,
    output accept,
    output drop,
    output hdr_done,
    input  busy
  );

  modport tx (
    input  hdr,
    input  ip,
    input  pld_len,
    input  accept,
    input  drop,
    output busy
  );

endinterface

`default_nettype wire

/* hw/icmp_strm_ifc.sv */
`default_nettype none
`timescale 1ns/1ps

// Byte stream, a message is a contiguous run of val from sof to eof
interface icmp_strm_ifc;

  logic [7:0] dat;
  logic       val;
  logic       sof;  // Only meaningful with val
  logic       eof;  // Only meaningful with val

  modport source (
    output dat,
    output val,
    output sof,
    output eof
  );

  modport sink (
    input dat,
    input val,
    input sof,
    input eof
  );

endinterface

`default_nettype wire

/* hw/icmp_pkg.sv */
`default_nettype none

package icmp_pkg;

  // Message type codes
  localparam logic [7:0] ICMP_ECHO_REPLY   = 8'd0;
  localparam logic [7:0] ICMP_ECHO_REQUEST = 8'd8;

  typedef logic [31:0] ip_addr_t;

  // Wire order, first byte in the MSBs
  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] cks;
    logic [15:0] id;
    logic [15:0] seq;
  } icmp_hdr_t;

  typedef struct packed {
    ip_addr_t    src;
    ip_addr_t    dst;
    logic [15:0] id;
    logic [7:0]  qos;
    logic [15:0] len;  // IPv4 total length
    logic [7:0]  ttl;
  } ipv4_meta_t;

endpackage

`default_nettype wire

/* hw/icmp_params.svh */
`ifndef ICMP_PARAMS_SVH
`define ICMP_PARAMS_SVH

// ICMP header length in bytes: type, code, checksum, identifier, sequence
`define ICMP_HDR_LEN 8

// Payload buffer depth in bytes, also the largest payload that gets a reply
`define ICMP_PLD_DEPTH 256

// TTL placed in the IPv4 fields of every reply
`define ICMP_REPLY_TTL 128

`endif
